/* all.f */
eth_tx_pkg.sv
frame_rd_if.sv
eth_frame_loader.sv
eth_frame_mem.sv
eth_crc32.sv
eth_mii_tx.sv
eth_tx_top.sv
tb_clock_gen.sv
tb_eth_tx.sv

/* eth_crc32.sv */
`timescale 1ns/100ps

module eth_crc32 (
   input  logic        TX_CLK,
   input  logic        tx_rst,
   input  logic        start,
   input  logic [7:0]  data_in,
   input  logic        data_en,
   output logic [31:0] crc_out
);

   // 0x04C11DB7 with its bits reversed
   localparam logic [31:0] POLY_REFL = 32'hEDB88320;

   // one byte, lsb first
   function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         if (c[0] ^ data[i])
            c = (c >> 1) ^ POLY_REFL;
         else
            c = c >> 1;
      end
      return c;
   endfunction

   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst)
         crc_out <= '1;
      else if (start)
         crc_out <= '1;
      else if (data_en)
         crc_out <= crc_step(crc_out, data_in);
   end

endmodule

/* eth_frame_loader.sv */
`timescale 1ns/100ps

module eth_frame_loader
   import eth_tx_pkg::*;
#(
   parameter int MEM_AW = 11
) (
   input  logic              TX_CLK,
   input  logic              tx_rst,
   input  logic              host_we,
   input  logic [7:0]        host_data,
   input  logic              host_last,
   output logic              host_ready,
   output logic              we,
   output logic [MEM_AW-1:0] waddr,
   output logic [7:0]        wdata,
   frame_rd_if.loader_side   rd
);

   loader_state_t state;

   // address of the delimiter, the last byte written by the loader itself
   localparam logic [MEM_AW-1:0] SFD_ADDR = MEM_AW'(PREAMBLE_LEN);

   assign host_ready = (state == accept);

   assign we = (state == init_preamble) || ((state == accept) && host_we);

   assign wdata = (state != init_preamble) ? host_data :
                  (waddr == SFD_ADDR)      ? SFD_BYTE  :
                                             PREAMBLE_BYTE;

   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst) begin
         state        <= init_preamble;
         waddr        <= '0;
         rd.frame_len <= '0;
         rd.send      <= 1'b0;
      end else begin
         rd.send <= 1'b0;
         case (state)
            init_preamble: begin
               waddr <= waddr + 1'b1;
               if (waddr == SFD_ADDR)
                  state <= accept;
            end
            accept: begin
               if (host_we) begin
                  waddr        <= waddr + 1'b1;
                  rd.frame_len <= rd.frame_len + 1'b1;
                  if (host_last) begin
                     state   <= wait_done;
                     rd.send <= 1'b1;
                  end
               end
            end
            wait_done: begin
               // ready is still high during the send cycle
               if (!rd.send && rd.ready) begin
                  state        <= init_preamble;
                  waddr        <= '0;
                  rd.frame_len <= '0;
               end
            end
            default: state <= init_preamble;
         endcase
      end
   end

endmodule

/* eth_frame_mem.sv */
`timescale 1ns/100ps

module eth_frame_mem #(
   parameter int MEM_AW = 11
) (
   input  logic              TX_CLK,
   input  logic              we,
   input  logic [MEM_AW-1:0] waddr,
   input  logic [7:0]        wdata,
   frame_rd_if.mem_side      rd
);

   // one frame, preamble included
   logic [7:0] mem [2**MEM_AW];

   always_ff @(posedge TX_CLK) begin
      if (we)
         mem[waddr] <= wdata;
   end

   // registered read, one cycle of latency
   always_ff @(posedge TX_CLK) begin
      rd.rd_data <= mem[rd.rd_addr];
   end

endmodule

/* eth_mii_tx.sv */
`timescale 1ns/100ps

module eth_mii_tx
   import eth_tx_pkg::*;
#(
   parameter int MEM_AW = 11
) (
   input  logic       TX_CLK,
   input  logic       tx_rst,
   frame_rd_if.tx_side rd,
   output logic       tx_en,
   output logic [3:0] tx_data
);

   tx_state_t state;

   // high nibble phase of the current byte
   logic              ph;
   logic [2:0]        nib_cnt;
   logic              crc_en;
   logic [31:0]       crc_value;
   logic [31:0]       fcs_word;
   logic [MEM_AW-1:0] pre_end;
   logic [MEM_AW-1:0] frame_end;

   // rd_addr runs one byte ahead of the byte on rd_data
   assign pre_end   = MEM_AW'(PREAMBLE_LEN + 1);
   assign frame_end = pre_end + rd.frame_len;

   // fold each frame byte while its high nibble goes out
   assign crc_en = (state == frame) && ph;

   // the engine already works on reflected bits, so only the inversion is left;
   // fcs_word[3:0] is the first nibble on the wire
   assign fcs_word = ~crc_value;

   eth_crc32 u_crc32 (
      .TX_CLK  (TX_CLK),
      .tx_rst  (tx_rst),
      .start   (rd.send),
      .data_in (rd.rd_data),
      .data_en (crc_en),
      .crc_out (crc_value)
   );

   always_ff @(posedge TX_CLK or posedge tx_rst) begin
      if (tx_rst) begin
         state      <= idle;
         ph         <= 1'b0;
         nib_cnt    <= '0;
         rd.rd_addr <= '0;
         rd.ready   <= 1'b1;
         tx_en      <= 1'b0;
         tx_data    <= '0;
      end else begin
         case (state)
            idle: begin
               ph      <= 1'b0;
               nib_cnt <= '0;
               if (rd.send) begin
                  rd.ready <= 1'b0;
                  state    <= preamble;
               end else begin
                  rd.ready <= 1'b1;
               end
            end
            preamble, frame: begin
               tx_en <= 1'b1;
               ph    <= ~ph;
               if (!ph) begin
                  tx_data    <= rd.rd_data[3:0];
                  rd.rd_addr <= rd.rd_addr + 1'b1;
               end else begin
                  tx_data <= rd.rd_data[7:4];
                  if ((state == preamble) && (rd.rd_addr == pre_end))
                     state <= (rd.frame_len == '0) ? fcs : frame;
                  else if ((state == frame) && (rd.rd_addr == frame_end))
                     state <= fcs;
               end
            end
            fcs: begin
               tx_data <= fcs_word[{nib_cnt, 2'b00} +: 4];
               nib_cnt <= nib_cnt + 1'b1;
               if (nib_cnt == 3'(2 * FCS_LEN - 1))
                  state <= finish;
            end
            finish: begin
               // ready comes back from idle one cycle later
               tx_en      <= 1'b0;
               rd.rd_addr <= '0;
               state      <= idle;
            end
            default: state <= idle;
         endcase
      end
   end

endmodule

/* eth_tx_cases.txt */
# name frame_len noise, then frame_len bytes in hex, then the expected CRC-32 in hex
# noise 1 adds junk host writes while host_ready is low; long frames wrap to a new line
min_hdr 14 0 6d 65 73 73 61 67 65 20 64 69 67 65 73 74 20159d7f
check_str 9 0 31 32 33 34 35 36 37 38 39 cbf43926
alphabet 26 1 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d
   6e 6f 70 71 72 73 74 75 76 77 78 79 7a 4c2750bd
abc 3 0 61 62 63 352441c2
fox 43 1 54 68 65 20 71 75 69 63 6b 20 62 72 6f 77 6e 20 66 6f 78 20
   6a 75 6d 70 73 20 6f 76 65 72 20 74 68 65 20 6c 61 7a 79 20 64 6f 67 414fa339
single 1 0 61 e8b7be43

/* eth_tx_pkg.sv */
package eth_tx_pkg;

   // preamble and start-of-frame delimiter
   localparam int          PREAMBLE_LEN  = 7;
   localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0]  SFD_BYTE      = 8'hD5;

   // dst + src + type
   localparam int          HDR_LEN       = 14;
   localparam int          FCS_LEN       = 4;

   typedef enum logic [1:0] {
      init_preamble,
      accept,
      wait_done
   } loader_state_t;

   typedef enum logic [2:0] {
      idle,
      preamble,
      frame,
      fcs,
      finish
   } tx_state_t;

endpackage

/* eth_tx_top.sv */
`timescale 1ns/100ps

module eth_tx_top #(
   parameter int MEM_AW = 11
) (
   input  logic       TX_CLK,
   input  logic       tx_rst,
   input  logic       host_we,
   input  logic [7:0] host_data,
   input  logic       host_last,
   output logic       host_ready,
   output logic       tx_en,
   output logic [3:0] tx_data
);

   // buffer write port
   logic              we;
   logic [MEM_AW-1:0] waddr;
   logic [7:0]        wdata;

   frame_rd_if #(
      .MEM_AW (MEM_AW)
   ) u_rd_if ();

   eth_frame_loader #(
      .MEM_AW (MEM_AW)
   ) u_loader (
      .TX_CLK     (TX_CLK),
      .tx_rst     (tx_rst),
      .host_we    (host_we),
      .host_data  (host_data),
      .host_last  (host_last),
      .host_ready (host_ready),
      .we         (we),
      .waddr      (waddr),
      .wdata      (wdata),
      .rd         (u_rd_if.loader_side)
   );

   eth_frame_mem #(
      .MEM_AW (MEM_AW)
   ) u_mem (
      .TX_CLK (TX_CLK),
      .we     (we),
      .waddr  (waddr),
      .wdata  (wdata),
      .rd     (u_rd_if.mem_side)
   );

   eth_mii_tx #(
      .MEM_AW (MEM_AW)
   ) u_mii_tx (
      .TX_CLK  (TX_CLK),
      .tx_rst  (tx_rst),
      .rd      (u_rd_if.tx_side),
      .tx_en   (tx_en),
      .tx_data (tx_data)
   );

endmodule

/* frame_rd_if.sv */
`timescale 1ns/100ps

interface frame_rd_if #(
   parameter int MEM_AW = 11
) ();

   logic [MEM_AW-1:0] rd_addr;
   logic [7:0]        rd_data;
   // bytes after the delimiter
   logic [MEM_AW-1:0] frame_len;
   logic              send;
   logic              ready;

   modport mem_side (
      input  rd_addr,
      output rd_data
   );

   modport loader_side (
      output frame_len,
      output send,
      input  ready
   );

   modport tx_side (
      output rd_addr,
      output ready,
      input  rd_data,
      input  frame_len,
      input  send
   );

endinterface

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
   parameter real PERIOD = 100.0
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2.0) clk = ~clk;
   end

endmodule

/* tb_eth_tx.sv */
`timescale 1ns/100ps

module tb_eth_tx
   import eth_tx_pkg::*;
();

   localparam int MEM_AW     = 11;
   localparam int MAX_LEN    = 256;
   localparam int WAIT_LIMIT = 200;
   localparam int CAP_LIMIT  = 2 * (8 + MAX_LEN + 4) + 16;

   logic       TX_CLK;
   logic       tx_rst;
   logic       host_we;
   logic [7:0] host_data;
   logic       host_last;
   logic       host_ready;
   logic       tx_en;
   logic [3:0] tx_data;

   logic [7:0]      frame [MAX_LEN];
   logic [3:0]      got_nibs [$];
   logic [3:0]      exp_nibs [$];
   logic [8*24-1:0] tname;
   logic [8*24-1:0] token;
   logic [8*200-1:0] line;
   int              errors;
   int              pass_count;
   int              fail_count;
   bit              noise;
   bit              timed_out;
   string           timeout_msg;

   tb_clock_gen #(
      .PERIOD (100.0)
   ) u_clk (
      .clk (TX_CLK)
   );

   eth_tx_top #(
      .MEM_AW (MEM_AW)
   ) u_eth_tx_top (
      .TX_CLK     (TX_CLK),
      .tx_rst     (tx_rst),
      .host_we    (host_we),
      .host_data  (host_data),
      .host_last  (host_last),
      .host_ready (host_ready),
      .tx_en      (tx_en),
      .tx_data    (tx_data)
   );

   task automatic check_value(input logic [8*24-1:0] test, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("[ERROR] %0s %s expected %0h actual %0h", test, what, expected, actual);
      end
   endtask

   task automatic report_test(input logic [8*24-1:0] test, input int errs_before);
      if (errors == errs_before) begin
         pass_count++;
         $display("test %0s passed", test);
      end else begin
         fail_count++;
         $display("test %0s failed", test);
      end
   endtask

   // junk host writes with host_last set while host_ready is low
   task automatic drive_host_noise();
      host_we   = noise && !host_ready;
      host_last = noise;
      host_data = 8'hA5;
   endtask

   task automatic wait_host_ready();
      int n;
      n = 0;
      while (!host_ready && !timed_out) begin
         @(negedge TX_CLK);
         drive_host_noise();
         n++;
         if (n > WAIT_LIMIT) begin
            timed_out   = 1'b1;
            timeout_msg = "timed out waiting for host_ready";
         end
      end
   endtask

   task automatic send_bytes(input int len);
      for (int i = 0; i < len; i++) begin
         host_we   = 1'b1;
         host_data = frame[i];
         host_last = (i == len - 1);
         @(negedge TX_CLK);
      end
      drive_host_noise();
   endtask

   task automatic wait_tx_en();
      int n;
      n = 0;
      while (!tx_en && !timed_out) begin
         @(negedge TX_CLK);
         drive_host_noise();
         n++;
         if (n > WAIT_LIMIT) begin
            timed_out   = 1'b1;
            timeout_msg = "timed out waiting for tx_en";
         end
      end
   endtask

   // one nibble per cycle while tx_en is high
   task automatic capture_frame(output int ready_cycles);
      ready_cycles = 0;
      got_nibs.delete();
      while (tx_en && !timed_out) begin
         got_nibs.push_back(tx_data);
         if (host_ready)
            ready_cycles++;
         @(negedge TX_CLK);
         drive_host_noise();
         if (got_nibs.size() > CAP_LIMIT) begin
            timed_out   = 1'b1;
            timeout_msg = "tx_en stayed high longer than any frame can last";
         end
      end
   endtask

   task automatic build_expected(input int len, input logic [31:0] fcs);
      exp_nibs.delete();
      for (int i = 0; i < 7; i++) begin
         exp_nibs.push_back(4'h5);
         exp_nibs.push_back(4'h5);
      end
      exp_nibs.push_back(4'h5);
      exp_nibs.push_back(4'hD);
      for (int i = 0; i < len; i++) begin
         exp_nibs.push_back(frame[i][3:0]);
         exp_nibs.push_back(frame[i][7:4]);
      end
      // fcs leaves least significant byte first
      for (int i = 0; i < 4; i++) begin
         exp_nibs.push_back(fcs[8*i +: 4]);
         exp_nibs.push_back(fcs[8*i+4 +: 4]);
      end
   endtask

   // stops at the first wrong nibble
   task automatic compare_stream(input logic [8*24-1:0] test);
      int n;
      int errs_start;
      n = (got_nibs.size() < exp_nibs.size()) ? got_nibs.size() : exp_nibs.size();
      errs_start = errors;
      for (int i = 0; i < n && errors == errs_start; i++)
         check_value(test, $sformatf("nibble %0d", i), exp_nibs[i], got_nibs[i]);
   endtask

   initial begin
      int          fd;
      int          code;
      int          len;
      int          nflag;
      int          n;
      int          ready_cycles;
      int          errs_before;
      int          ncases;
      logic [7:0]  b;
      logic [31:0] fcs;
      logic [31:0] rx_fcs;

      host_we     = 1'b0;
      host_data   = 8'h00;
      host_last   = 1'b0;
      tx_rst      = 1'b1;
      noise       = 1'b0;
      timed_out   = 1'b0;
      timeout_msg = "";
      errors      = 0;
      pass_count  = 0;
      fail_count  = 0;
      ncases      = 0;
      repeat (8) @(negedge TX_CLK);
      tx_rst = 1'b0;

      tname       = "reset";
      errs_before = errors;
      check_value(tname, "tx_en after reset", 0, tx_en);
      check_value(tname, "host_ready after reset", 0, host_ready);
      n = 0;
      while (!host_ready && n <= WAIT_LIMIT) begin
         @(negedge TX_CLK);
         n++;
      end
      if (!host_ready) begin
         timed_out   = 1'b1;
         timeout_msg = "timed out waiting for host_ready after reset";
      end else begin
         check_value(tname, "cycles before host_ready", 8, n);
         report_test(tname, errs_before);
      end

      fd = $fopen("eth_tx_cases.txt", "r");
      if (fd == 0)
         $display("could not open eth_tx_cases.txt");
      while (fd != 0 && !timed_out && !$feof(fd)) begin
         code = $fscanf(fd, "%s", token);
         if (code != 1)
            break;
         if (token == "#") begin
            code = $fgets(line, fd);
            continue;
         end
         tname = token;
         code  = $fscanf(fd, "%d %d", len, nflag);
         if (code != 2 || len < 1 || len > MAX_LEN) begin
            $display("case %0s has a bad length or flag field", tname);
            fail_count++;
            break;
         end
         for (int i = 0; i < len; i++) begin
            code     = $fscanf(fd, "%h", b);
            frame[i] = b;
         end
         code = $fscanf(fd, "%h", fcs);
         ncases++;
         if (len < HDR_LEN)
            $display("case %0s is shorter than a header", tname);
         noise       = (nflag != 0);
         errs_before = errors;
         build_expected(len, fcs);
         wait_host_ready();
         if (!timed_out)
            send_bytes(len);
         if (!timed_out)
            wait_tx_en();
         if (!timed_out)
            capture_frame(ready_cycles);
         if (!timed_out) begin
            check_value(tname, "tx_en cycles", 2 * (8 + len + FCS_LEN), got_nibs.size());
            check_value(tname, "host_ready cycles during tx", 0, ready_cycles);
            compare_stream(tname);
            if (got_nibs.size() >= 8) begin
               rx_fcs = '0;
               for (int i = 0; i < 8; i++)
                  rx_fcs[4*i +: 4] = got_nibs[got_nibs.size() - 8 + i];
               check_value(tname, "fcs", fcs, rx_fcs);
            end
            report_test(tname, errs_before);
         end
      end
      if (fd != 0)
         $fclose(fd);

      if (timed_out)
         $display("%0s", timeout_msg);
      $display("tests passed %0d, failed %0d", pass_count, fail_count);
      if (timed_out || errors != 0 || fail_count != 0 || ncases == 0)
         $display("=== FAIL ===");
      else
         $display("=== PASS ===");
      $finish;
   end

endmodule
